// File: build.f
+incdir+include
hw/cart_pkg.sv
hw/load_word_if.sv
hw/load_sequencer.sv
hw/load_addr_counter.sv
hw/cart_header_parser.sv
hw/cheat_code_assembler.sv
hw/cart_load_top.sv
verif/tb_clock.sv
verif/cart_load_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the cartridge loader testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-f build.f \
	--top-module cart_load_tb \
	-o sim_cart_load
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_cart_load)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "test passed" <<< "$sim_out"; then
	exit 0
fi
exit 1

// File: verif/cart_load_tb.sv
/* directed tests for the cartridge loading path: memory responder,
   bus monitor, watchdog and closing summary */
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_load_tb;

	typedef logic [128:0] wide_t;

	// words per test size the watchdog
	localparam int STREAM_WORDS = 64;
	localparam int HEADER_WORDS = 'h200 / 2 + 1;
	localparam int ID_WORDS = 'h18C / 2 + 1;
	localparam int CODE_WORDS = 16;
	localparam int TOTAL_WORDS = STREAM_WORDS + HEADER_WORDS + 3 * ID_WORDS + CODE_WORDS;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 16 + 1000;

	logic clk_sys;
	logic rst_n;
	logic load_active;
	logic code_sel;
	logic in_strobe;
	logic [`CART_WORD_W-1:0] in_data;
	logic load_wait;
	logic mem_ack;
	logic mem_req;
	logic [`CART_ADDR_W-1:0] mem_addr;
	logic [`CART_WORD_W-1:0] mem_data;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;
	cart_pkg::quirk_flags_t quirks;
	logic gun_type;
	logic [`GUN_DELAY_W-1:0] gun_delay;
	logic [`CHEAT_CODE_W-1:0] code;
	logic code_valid;
	logic code_clear;

	int value_errors = 0;
	int protocol_errors = 0;
	// monitor counters sampled on the falling edge
	int req_toggles = 0;
	int wait_cycles = 0;
	int valid_pulses = 0;
	int clear_pulses = 0;
	logic [31:0] data_rng;
	logic [31:0] ack_rng;
	// responder log of memory writes
	logic [`CART_ADDR_W-1:0] log_addr[$];
	logic [`CART_WORD_W-1:0] log_data[$];
	wide_t code_log[$];

	tb_clock i_clock (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	cart_load_top i_cart_load_top (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.load_active (load_active),
		.code_sel    (code_sel),
		.in_strobe   (in_strobe),
		.in_data     (in_data),
		.load_wait   (load_wait),
		.mem_ack     (mem_ack),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.hdr_j       (hdr_j),
		.hdr_u       (hdr_u),
		.hdr_e       (hdr_e),
		.hdr_ready   (hdr_ready),
		.quirks      (quirks),
		.gun_type    (gun_type),
		.gun_delay   (gun_delay),
		.code        (code),
		.code_valid  (code_valid),
		.code_clear  (code_clear)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_mismatch(input string tname, input string what,
			input wide_t expected, input wide_t actual);
		value_errors++;
		$display("Fail %s %s: expected 0x%0h, actual 0x%0h", tname, what, expected, actual);
	endtask

	task automatic report_problem(input string msg);
		protocol_errors++;
		$display("%s", msg);
	endtask

	// header image with address pattern, id bytes and region letters
	function automatic logic [15:0] image_word(input logic [24:0] addr, input logic [63:0] id);
		logic [15:0] w;
		w = addr[15:0] ^ 16'hA5C3;
		case (addr)
			25'h182: w = {id[63:56], w[7:0]};
			25'h184: w = {id[47:40], id[55:48]};
			25'h186: w = {id[31:24], id[39:32]};
			25'h188: w = {id[15:8], id[23:16]};
			25'h18A: w = {w[15:8], id[7:0]};
			25'h1F0: w = {"J", "U"};
			25'h1F2: w = {w[15:8], "E"};
			default: w = w;
		endcase
		return w;
	endfunction

	// half-word k of a code {flags, address, compare, replace} with low half first
	function automatic logic [15:0] code_word(input logic [127:0] c, input int k);
		int f;
		int half;
		f = k / 2;
		half = k % 2;
		return c[(3 - f) * 32 + half * 16 +: 16];
	endfunction

	task automatic wait_for_level(input logic level, input string msg);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (load_wait !== level && n < 32);
		if (load_wait !== level) report_problem(msg);
	endtask

	// one strobe and then honour the stall in cart mode
	task automatic send_word(input logic [15:0] w, input logic is_code);
		@(posedge clk_sys);
		in_strobe <= 1'b1;
		in_data <= w;
		@(posedge clk_sys);
		in_strobe <= 1'b0;
		if (!is_code) begin
			wait_for_level(1'b1, "load_wait did not rise after a cart word");
			wait_for_level(1'b0, "load_wait stayed high, the write was never acknowledged");
		end
	endtask

	task automatic start_load(input logic is_code);
		@(posedge clk_sys);
		code_sel <= is_code;
		load_active <= 1'b1;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic end_load();
		@(posedge clk_sys);
		load_active <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic check_reset_values();
		@(negedge clk_sys);
		if (load_wait !== 1'b0) report_mismatch("reset", "load_wait", 0, wide_t'(load_wait));
		if (mem_req !== 1'b0) report_mismatch("reset", "mem_req", 0, wide_t'(mem_req));
		if (code_valid !== 1'b0) report_mismatch("reset", "code_valid", 0, wide_t'(code_valid));
		if (code_clear !== 1'b0) report_mismatch("reset", "code_clear", 0, wide_t'(code_clear));
		if (hdr_ready !== 1'b0) report_mismatch("reset", "hdr_ready", 0, wide_t'(hdr_ready));
		if (quirks !== 8'h00) report_mismatch("reset", "quirks", 0, wide_t'(quirks));
		if (gun_type !== 1'b0) report_mismatch("reset", "gun_type", 0, wide_t'(gun_type));
		if (gun_delay !== 8'd44) report_mismatch("reset", "gun_delay", 44, wide_t'(gun_delay));
	endtask

	task automatic check_cart_stream();
		logic [15:0] stream[STREAM_WORDS];
		for (int i = 0; i < STREAM_WORDS; i++) begin
			data_rng = xorshift32(data_rng);
			stream[i] = data_rng[15:0];
		end
		log_addr.delete();
		log_data.delete();
		start_load(1'b0);
		for (int i = 0; i < STREAM_WORDS; i++) send_word(stream[i], 1'b0);
		end_load();
		if (log_addr.size() != STREAM_WORDS) begin
			report_mismatch("cart_stream", "write count", STREAM_WORDS, log_addr.size());
		end
		for (int i = 0; i < STREAM_WORDS && i < log_addr.size(); i++) begin
			// memory takes the word with its bytes swapped
			if (log_addr[i] !== 25'(2 * i)) begin
				report_mismatch("cart_stream", "mem_addr", 2 * i, wide_t'(log_addr[i]));
			end
			if (log_data[i] !== {stream[i][7:0], stream[i][15:8]}) begin
				report_mismatch("cart_stream", "mem_data",
					wide_t'({stream[i][7:0], stream[i][15:8]}), wide_t'(log_data[i]));
			end
		end
	endtask

	task automatic check_header_region();
		start_load(1'b0);
		for (int a = 0; a < 'h200; a += 2) send_word(image_word(25'(a), "XX-00000"), 1'b0);
		@(negedge clk_sys);
		if (hdr_ready !== 1'b0) report_mismatch("header", "hdr_ready early", 0, wide_t'(hdr_ready));
		send_word(image_word(25'h200, "XX-00000"), 1'b0);
		@(negedge clk_sys);
		if (hdr_ready !== 1'b1) report_mismatch("header", "hdr_ready", 1, wide_t'(hdr_ready));
		if (hdr_j !== 1'b1) report_mismatch("header", "hdr_j", 1, wide_t'(hdr_j));
		if (hdr_u !== 1'b1) report_mismatch("header", "hdr_u", 1, wide_t'(hdr_u));
		if (hdr_e !== 1'b1) report_mismatch("header", "hdr_e", 1, wide_t'(hdr_e));
		end_load();
		@(negedge clk_sys);
		if (hdr_ready !== 1'b0) report_mismatch("header", "hdr_ready end", 0, wide_t'(hdr_ready));
	endtask

	// send the id up to the lookup word and compare quirks and gun pair
	task automatic check_id(input logic [63:0] id, input cart_pkg::quirk_flags_t exp_q,
			input logic exp_type, input logic [7:0] exp_delay);
		start_load(1'b0);
		for (int a = 0; a <= 'h18C; a += 2) send_word(image_word(25'(a), id), 1'b0);
		repeat (3) @(negedge clk_sys);
		if (quirks !== exp_q) report_mismatch("quirk_lookup", "quirks", wide_t'(exp_q),
			wide_t'(quirks));
		if (gun_type !== exp_type) report_mismatch("quirk_lookup", "gun_type",
			wide_t'(exp_type), wide_t'(gun_type));
		if (gun_delay !== exp_delay) report_mismatch("quirk_lookup", "gun_delay",
			wide_t'(exp_delay), wide_t'(gun_delay));
		end_load();
	endtask

	task automatic check_quirk_lookup();
		cart_pkg::quirk_flags_t q;
		q = '0;
		q.fifo = 1'b1;
		check_id("T-89016 ", q, 1'b0, 8'd44);
		check_id("T-95096-", '0, 1'b1, 8'd52);
		check_id("XX-00000", '0, 1'b0, 8'd44);
	endtask

	task automatic check_cheat_codes();
		logic [127:0] codes[2];
		int toggles0;
		int waits0;
		int valid0;
		int clear0;
		codes[0] = {32'h0000_0001, 32'h00FF_1234, 32'h0000_4E75, 32'h0000_6002};
		codes[1] = {32'h0000_0003, 32'h00E0_0100, 32'h0000_0063, 32'h0000_0099};
		code_log.delete();
		toggles0 = req_toggles;
		waits0 = wait_cycles;
		valid0 = valid_pulses;
		clear0 = clear_pulses;
		start_load(1'b1);
		for (int i = 0; i < CODE_WORDS; i++) send_word(code_word(codes[i / 8], i % 8), 1'b1);
		repeat (4) @(posedge clk_sys);
		end_load();
		if (clear_pulses - clear0 != 1) report_mismatch("cheat", "code_clear pulses", 1,
			clear_pulses - clear0);
		if (valid_pulses - valid0 != 2) report_mismatch("cheat", "code_valid pulses", 2,
			valid_pulses - valid0);
		if (req_toggles != toggles0) report_problem("mem_req toggled during a cheat code load");
		if (wait_cycles != waits0) report_problem("load_wait went high during a cheat code load");
		for (int i = 0; i < 2 && i < code_log.size(); i++) begin
			if (code_log[i] !== {1'b1, codes[i]}) begin
				report_mismatch("cheat", "code", {1'b1, codes[i]}, code_log[i]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// memory responder with a random ack delay of 0 to 7 cycles
	////////////////////////////////////////////////////////////

	initial begin
		logic busy;
		logic [2:0] count;
		mem_ack = 1'b0;
		busy = 1'b0;
		count = 3'd0;
		ack_rng = 32'h363c;
		forever begin
			@(posedge clk_sys);
			if (!rst_n) begin
				mem_ack <= 1'b0;
				busy = 1'b0;
			end else if (busy) begin
				if (count == 3'd0) begin
					mem_ack <= mem_req;
					busy = 1'b0;
				end else begin
					count = count - 3'd1;
				end
			end else if (mem_req != mem_ack) begin
				// log a new write before acknowledging it
				log_addr.push_back(mem_addr);
				log_data.push_back(mem_data);
				ack_rng = xorshift32(ack_rng);
				if (ack_rng[2:0] == 3'd0) begin
					mem_ack <= mem_req;
				end else begin
					busy = 1'b1;
					count = ack_rng[2:0] - 3'd1;
				end
			end
		end
	end

	// falling-edge monitor of handshake and pulses
	initial begin
		logic req_q;
		logic ack_q;
		req_q = 1'b0;
		ack_q = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (mem_req !== req_q) begin
				req_toggles++;
				if (req_q !== ack_q) begin
					report_problem(
						"mem_req toggled before the last write was acknowledged");
				end
			end
			if (load_wait === 1'b1) wait_cycles++;
			if (code_clear === 1'b1) clear_pulses++;
			if (code_valid === 1'b1) begin
				valid_pulses++;
				code_log.push_back(code);
			end
			req_q = mem_req;
			ack_q = mem_ack;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		load_active = 1'b0;
		code_sel = 1'b0;
		in_strobe = 1'b0;
		in_data = '0;
		data_rng = 32'h363c;
		wait (rst_n === 1'b1);
		check_reset_values();
		check_cart_stream();
		check_header_region();
		check_quirk_lookup();
		check_cheat_codes();
		$display("summary: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verif/tb_clock.sv
/* testbench clock and reset generator */
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD_NS = 50,
	parameter int RESET_CYCLES   = 16
) (
	output logic clk_sys,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD_NS) clk_sys = ~clk_sys;
	end

	// reset held low for a fixed number of rising edges
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		rst_n <= 1'b1;
	end

endmodule

// File: hw/cart_load_top.sv
/* cartridge loading path top level: sequencer, address counter,
   header parser and cheat assembler on one word bus */
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_load_top (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	// word source
	input  logic                     load_active,
	input  logic                     code_sel,
	input  logic                     in_strobe,
	input  logic [`CART_WORD_W-1:0]  in_data,
	output logic                     load_wait,
	// memory write port
	input  logic                     mem_ack,
	output logic                     mem_req,
	output logic [`CART_ADDR_W-1:0]  mem_addr,
	output logic [`CART_WORD_W-1:0]  mem_data,
	// header results
	output logic                     hdr_j,
	output logic                     hdr_u,
	output logic                     hdr_e,
	output logic                     hdr_ready,
	output cart_pkg::quirk_flags_t   quirks,
	output logic                     gun_type,
	output logic [`GUN_DELAY_W-1:0]  gun_delay,
	// cheat codes
	output logic [`CHEAT_CODE_W-1:0] code,
	output logic                     code_valid,
	output logic                     code_clear
);

	load_word_if words ();

	load_sequencer i_seq (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.load_active (load_active),
		.code_sel    (code_sel),
		.in_strobe   (in_strobe),
		.in_data     (in_data),
		.mem_ack     (mem_ack),
		.mem_req     (mem_req),
		.mem_data    (mem_data),
		.load_wait   (load_wait),
		.words       (words.issue)
	);

	load_addr_counter i_addr (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.words    (words.addr_gen),
		.mem_addr (mem_addr)
	);

	cart_header_parser i_hdr (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.load_active (load_active),
		.words       (words.sink),
		.hdr_j       (hdr_j),
		.hdr_u       (hdr_u),
		.hdr_e       (hdr_e),
		.hdr_ready   (hdr_ready),
		.quirks      (quirks),
		.gun_type    (gun_type),
		.gun_delay   (gun_delay)
	);

	cheat_code_assembler i_cheat (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.words      (words.sink),
		.code       (code),
		.code_valid (code_valid),
		.code_clear (code_clear)
	);

endmodule

// File: hw/cheat_code_assembler.sv
/* cheat code assembly from code-mode words, clock-in and clear pulses */
`timescale 1ns/1ps
`include "cart_settings.svh"

module cheat_code_assembler (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	load_word_if.sink                words,
	output logic [`CHEAT_CODE_W-1:0] code,
	output logic                     code_valid,
	output logic                     code_clear
);

	// flags, address, compare, replace below the clock bit
	logic [`CHEAT_CODE_W-2:0] fields;
	logic clock_bit;
	logic code_word;

	assign code_word = words.word_strobe & words.code_mode;

	// 16 bytes per code, low nibble of the address picks the half-word
	always_ff @(posedge clk_sys) begin
		if (code_word) begin
			case (words.word_addr[3:0])
				4'd0: fields[111:96] <= words.word_data;
				4'd2: fields[127:112] <= words.word_data;
				4'd4: fields[79:64] <= words.word_data;
				4'd6: fields[95:80] <= words.word_data;
				4'd8: fields[47:32] <= words.word_data;
				4'd10: fields[63:48] <= words.word_data;
				4'd12: fields[15:0] <= words.word_data;
				4'd14: fields[31:16] <= words.word_data;
				default: fields <= fields;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clock_bit <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			// last half-word completes the code
			clock_bit <= code_word && (words.word_addr[3:0] == 4'd14);
			// first word of the load wipes the code list
			code_clear <= code_word && (words.word_addr == '0);
		end
	end

	assign code = {clock_bit, fields};
	assign code_valid = clock_bit;

endmodule

// File: hw/cart_header_parser.sv
/* cartridge header decode: region letters, product id capture,
   quirk and light-gun table lookup */
`timescale 1ns/1ps
`include "cart_settings.svh"

module cart_header_parser (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    load_active,
	load_word_if.sink               words,
	output logic                    hdr_j,
	output logic                    hdr_u,
	output logic                    hdr_e,
	output logic                    hdr_ready,
	output cart_pkg::quirk_flags_t  quirks,
	output logic                    gun_type,
	output logic [`GUN_DELAY_W-1:0] gun_delay
);

	localparam int DELAY_W = `GUN_DELAY_W;
	localparam logic [`CART_ADDR_W-1:0] ADDR_STEP = 2;
	// id words after the first one
	localparam logic [`CART_ADDR_W-1:0] ID_ADDR_1 = `HDR_ID_FIRST_ADDR + ADDR_STEP;
	localparam logic [`CART_ADDR_W-1:0] ID_ADDR_2 = ID_ADDR_1 + ADDR_STEP;
	localparam logic [`CART_ADDR_W-1:0] ID_ADDR_3 = ID_ADDR_2 + ADDR_STEP;
	localparam logic [`CART_ADDR_W-1:0] ID_ADDR_4 = ID_ADDR_3 + ADDR_STEP;

	logic        hdr_word;
	logic [7:0]  lo_byte;
	logic [7:0]  hi_byte;
	logic [2:0]  region_hit;
	logic [63:0] cart_id;

	// {j, u, e} for one region character
	function automatic logic [2:0] region_of(input logic [7:0] ch);
		logic [2:0] r;
		r = 3'b000;
		if (ch == "J") begin
			r = 3'b100;
		end else if (ch == "U") begin
			r = 3'b010;
		end else if (ch >= "0" && ch <= "Z") begin
			r = 3'b001;
		end
		return r;
	endfunction

	// known titles, at most one flag per id
	function automatic cart_pkg::quirk_flags_t quirk_of(input logic [63:0] id);
		cart_pkg::quirk_flags_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ": q.sram = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ": q.eeprom = 1'b1;
			"00004076", "T-12046 ", "T-12053 ", "G-4524  ": q.eeprom = 1'b1;
			"T-113016": q.noram = 1'b1;
			"T-89016 ": q.fifo = 1'b1;
			"T-574023", "T-574013": q.pier = 1'b1;
			"MK-1229 ", "G-7001  ": q.svp = 1'b1;
			"T-35036 ", "T-25073 ", "MK-1137-": q.fmbusy = 1'b1;
			"T-68???-": q.schan = 1'b1;
			default: q = '0;
		endcase
		return q;
	endfunction

	// header is only looked at in cart loads
	assign hdr_word = words.word_strobe & ~words.code_mode;
	assign lo_byte = words.word_data[7:0];
	assign hi_byte = words.word_data[15:8];

	always_comb begin
		region_hit = 3'b000;
		if (words.word_addr == `HDR_REGION_ADDR_A || words.word_addr == `HDR_REGION_ADDR_B) begin
			region_hit = region_of(lo_byte);
		end
		// first region word carries a letter in both halves
		if (words.word_addr == `HDR_REGION_ADDR_A) begin
			region_hit = region_hit | region_of(hi_byte);
		end
	end

	////////////////////////////////////////////////////////////
	// region flags and header ready
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready <= 1'b0;
		end else begin
			if (words.start) begin
				{hdr_j, hdr_u, hdr_e} <= 3'b000;
			end else if (hdr_word) begin
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | region_hit;
			end
			if (!load_active) begin
				hdr_ready <= 1'b0;
			end else if (hdr_word && words.word_addr == `HDR_READY_ADDR) begin
				hdr_ready <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// product id, ascii, first char in the top byte
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (hdr_word) begin
			case (words.word_addr)
				`HDR_ID_FIRST_ADDR: cart_id[63:56] <= hi_byte;
				ID_ADDR_1: cart_id[55:40] <= {lo_byte, hi_byte};
				ID_ADDR_2: cart_id[39:24] <= {lo_byte, hi_byte};
				ID_ADDR_3: cart_id[23:8] <= {lo_byte, hi_byte};
				ID_ADDR_4: cart_id[7:0] <= lo_byte;
				default: cart_id <= cart_id;
			endcase
		end
	end

	// quirks and gun settings, looked up once the id is in
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			quirks <= '0;
			gun_type <= 1'b0;
			gun_delay <= DELAY_W'(`GUN_DELAY_DEFAULT);
		end else if (words.start) begin
			quirks <= '0;
		end else if (hdr_word && words.word_addr == `HDR_ID_DONE_ADDR) begin
			quirks <= quirk_of(cart_id);
			case (cart_id)
				"MK-1533 ": begin
					gun_type <= 1'b0;
					gun_delay <= DELAY_W'(100);
				end
				"T-95096-": begin
					gun_type <= 1'b1;
					gun_delay <= DELAY_W'(52);
				end
				"T-95136-": begin
					gun_type <= 1'b1;
					gun_delay <= DELAY_W'(30);
				end
				"MK-1658 ": begin
					gun_type <= 1'b0;
					gun_delay <= DELAY_W'(120);
				end
				"T-081156": begin
					gun_type <= 1'b0;
					gun_delay <= DELAY_W'(126);
				end
				default: begin
					// menacer timing for everything else
					gun_type <= 1'b0;
					gun_delay <= DELAY_W'(`GUN_DELAY_DEFAULT);
				end
			endcase
		end
	end

endmodule

// File: hw/load_addr_counter.sv
/* byte address counter for the words of a load */
`timescale 1ns/1ps
`include "cart_settings.svh"

module load_addr_counter (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	load_word_if.addr_gen           words,
	output logic [`CART_ADDR_W-1:0] mem_addr
);

	// two bytes per word
	localparam logic [`CART_ADDR_W-1:0] WORD_BYTES = 2;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			words.word_addr <= '0;
		end else if (words.start) begin
			words.word_addr <= '0;
		end else if (words.word_strobe) begin
			// advance after the strobe, sinks saw the current address
			words.word_addr <= words.word_addr + WORD_BYTES;
		end
	end

	// write address, lines up with mem_req toggle
	always_ff @(posedge clk_sys) begin
		if (words.word_strobe) begin
			mem_addr <= words.word_addr;
		end
	end

endmodule

// File: hw/load_sequencer.sv
/* loader FSM: word acceptance, toggle req/ack write to memory
   and source stall */
`timescale 1ns/1ps
`include "cart_settings.svh"

module load_sequencer (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    load_active,
	input  logic                    code_sel,
	input  logic                    in_strobe,
	input  logic [`CART_WORD_W-1:0] in_data,
	input  logic                    mem_ack,
	output logic                    mem_req,
	output logic [`CART_WORD_W-1:0] mem_data,
	output logic                    load_wait,
	load_word_if.issue              words
);

	cart_pkg::load_state_e state;
	logic active_q;
	logic active_rise;
	logic accept;
	logic launch;

	assign active_rise = load_active & ~active_q;
	// source words only count while loading
	assign accept = in_strobe & (state == cart_pkg::st_loading);
	// cart word one cycle after acceptance goes out to memory
	assign launch = words.word_strobe & ~words.code_mode & (state == cart_pkg::st_loading);

	// stall the source for the whole write
	assign load_wait = (state == cart_pkg::st_wait_ack);

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= cart_pkg::st_idle;
			active_q <= 1'b0;
			words.start <= 1'b0;
			words.word_strobe <= 1'b0;
			words.code_mode <= 1'b0;
			mem_req <= 1'b0;
		end else begin
			active_q <= load_active;
			words.start <= active_rise;
			words.word_strobe <= accept;
			if (accept) begin
				words.code_mode <= code_sel;
			end

			case (state)
				cart_pkg::st_idle: begin
					if (active_rise) begin
						state <= cart_pkg::st_loading;
					end
				end
				cart_pkg::st_loading: begin
					if (launch) begin
						// new request, ack still holds the old level
						mem_req <= ~mem_req;
						state <= cart_pkg::st_wait_ack;
					end else if (!load_active) begin
						state <= cart_pkg::st_idle;
					end
				end
				cart_pkg::st_wait_ack: begin
					// write done once ack catches up with req
					if (mem_ack == mem_req) begin
						state <= load_active ? cart_pkg::st_loading : cart_pkg::st_idle;
					end
				end
				default: state <= cart_pkg::st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// data
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			words.word_data <= in_data;
		end
		// memory is big endian, swap the byte lanes
		if (launch) begin
			mem_data <= {words.word_data[7:0], words.word_data[15:8]};
		end
	end

endmodule

// File: hw/load_word_if.sv
/* accepted-word bus from the loader FSM and address counter
   to the header parser and cheat assembler */
`timescale 1ns/1ps
`include "cart_settings.svh"

interface load_word_if;

	// one cycle at the rising edge of load_active
	logic start;
	// one cycle per accepted word
	logic word_strobe;
	logic [`CART_WORD_W-1:0] word_data;
	// high for cheat code loads
	logic code_mode;
	// byte address of the word on word_strobe
	logic [`CART_ADDR_W-1:0] word_addr;

	modport issue (
		output start,
		output word_strobe,
		output word_data,
		output code_mode
	);

	modport addr_gen (
		input  start,
		input  word_strobe,
		output word_addr
	);

	modport sink (
		input start,
		input word_strobe,
		input word_data,
		input code_mode,
		input word_addr
	);

endinterface

// File: hw/cart_pkg.sv
/* shared types: loader FSM states and cartridge quirk flags */
package cart_pkg;

	////////////////////////////////////////////////////////////
	// loader FSM
	////////////////////////////////////////////////////////////

	// st_idle     no load running
	// st_loading  words accepted from the source
	// st_wait_ack memory write in flight, source stalled
	typedef enum logic [1:0] {
		st_idle,
		st_loading,
		st_wait_ack
	} load_state_e;

	////////////////////////////////////////////////////////////
	// per-cartridge quirks, one bit each
	////////////////////////////////////////////////////////////

	typedef struct packed {
		// battery ram mapped in rom space
		logic sram;
		// serial eeprom save
		logic eeprom;
		// fast vdp fifo timing
		logic fifo;
		// hide cart ram from protection check
		logic noram;
		// pier solar mapper
		logic pier;
		// svp coprocessor present
		logic svp;
		// fm busy flag emulation
		logic fmbusy;
		// odd channel handling for one title
		logic schan;
	} quirk_flags_t;

endpackage

// File: include/cart_settings.svh
/* widths, cartridge header addresses and light-gun defaults
   for the cartridge loading path */
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

////////////////////////////////////////////////////////////
// data path widths
////////////////////////////////////////////////////////////

// one word per strobe from the loader source
`define CART_WORD_W 16
// byte address into cartridge memory, 32 MB
`define CART_ADDR_W 25
// {clock bit, flags, address, compare, replace}
`define CHEAT_CODE_W 129

////////////////////////////////////////////////////////////
// header layout, byte addresses of 16-bit words
////////////////////////////////////////////////////////////

// product id starts in the low half of this word
`define HDR_ID_FIRST_ADDR 25'h182
// id is complete here, table lookup fires
`define HDR_ID_DONE_ADDR 25'h18C
// region letters
`define HDR_REGION_ADDR_A 25'h1F0
`define HDR_REGION_ADDR_B 25'h1F2
// first word past the header
`define HDR_READY_ADDR 25'h200

////////////////////////////////////////////////////////////
// light gun
////////////////////////////////////////////////////////////

`define GUN_DELAY_W 8
`define GUN_DELAY_DEFAULT 44

`endif
